// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_mem_subsys
FILELIST = verilog.f
BUILD    = obj_dir
PASS_MSG = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | awk -v pat="$(PASS_MSG)" '{ print } $$0 == pat { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD)

// ==== hdl/bus_pkg.sv ====
`include "mem_settings.svh"

package bus_pkg;

    typedef logic [`MEM_ADDR_W-1:0]   addr_t;
    typedef logic [`MEM_DATA_W-1:0]   data_t;
    typedef logic [`MEM_DATA_W/8-1:0] strb_t;

    // one code past the last region marks an unmapped address
    localparam int REGION_W = $clog2(`MEM_NUM_REGIONS + 1);

    typedef logic [REGION_W-1:0] region_t;

    localparam region_t REGION_NONE = region_t'(`MEM_NUM_REGIONS);

    typedef struct packed {
        logic  we;
        addr_t adr;
        data_t dat;
        strb_t sel;   // byte enables, ignored on reads
    } wb_req_t;

endpackage

// ==== hdl/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// word and address widths
`define MEM_DATA_W 32
`define MEM_ADDR_W 32

// cached RAM and uncached MMIO
`define MEM_NUM_REGIONS 2

// entries per port queue and in the order queue
`define MEM_QUEUE_DEPTH 4

`endif

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_top (
    input  logic                                  i_clk,
    input  logic                                  i_reset,

    input  logic                                  i_req_valid,
    input  logic                                  i_req_we,
    input  bus_pkg::addr_t                        i_req_addr,
    input  bus_pkg::data_t                        i_req_wdata,
    input  bus_pkg::strb_t                        i_req_strb,
    output logic                                  o_req_ready,

    output logic                                  o_resp_valid,
    output bus_pkg::data_t                        o_resp_rdata,
    output logic                                  o_resp_err,
    input  logic                                  i_resp_ready,

    // one wishbone master per region
    output logic [`MEM_NUM_REGIONS-1:0]           o_wb_cyc,
    output logic [`MEM_NUM_REGIONS-1:0]           o_wb_stb,
    output logic [`MEM_NUM_REGIONS-1:0]           o_wb_we,
    output bus_pkg::addr_t [`MEM_NUM_REGIONS-1:0] o_wb_adr,
    output bus_pkg::data_t [`MEM_NUM_REGIONS-1:0] o_wb_dat_w,
    output bus_pkg::strb_t [`MEM_NUM_REGIONS-1:0] o_wb_sel,
    input  bus_pkg::data_t [`MEM_NUM_REGIONS-1:0] i_wb_dat_r,
    input  logic [`MEM_NUM_REGIONS-1:0]           i_wb_ack
);
    import bus_pkg::*;

    // router - ports
    logic [`MEM_NUM_REGIONS-1:0]  port_push;
    logic [`MEM_NUM_REGIONS-1:0]  port_full;
    wb_req_t                      port_entry;

    // router - order queue
    logic                         order_push;
    logic                         order_full;
    region_t                      order_tag;

    // ports - merger
    logic [`MEM_NUM_REGIONS-1:0]  port_done;
    logic [`MEM_NUM_REGIONS-1:0]  port_take;
    data_t [`MEM_NUM_REGIONS-1:0] port_rdata;

    req_router u_req_router (
        .i_clk        ( i_clk        ),
        .i_reset      ( i_reset      ),
        .i_req_valid  ( i_req_valid  ),
        .i_req_we     ( i_req_we     ),
        .i_req_addr   ( i_req_addr   ),
        .i_req_wdata  ( i_req_wdata  ),
        .i_req_strb   ( i_req_strb   ),
        .i_port_full  ( port_full    ),
        .i_order_full ( order_full   ),
        .o_req_ready  ( o_req_ready  ),
        .o_port_push  ( port_push    ),
        .o_port_entry ( port_entry   ),
        .o_order_push ( order_push   ),
        .o_order_tag  ( order_tag    )
    );

    for (genvar r = 0; r < `MEM_NUM_REGIONS; r++) begin : g_port
        wb_master_port u_port (
            .i_clk      ( i_clk         ),
            .i_reset    ( i_reset       ),
            .i_push     ( port_push[r]  ),
            .i_entry    ( port_entry    ),   // shared, push picks the port
            .o_full     ( port_full[r]  ),
            .o_wb_cyc   ( o_wb_cyc[r]   ),
            .o_wb_stb   ( o_wb_stb[r]   ),
            .o_wb_we    ( o_wb_we[r]    ),
            .o_wb_adr   ( o_wb_adr[r]   ),
            .o_wb_dat_w ( o_wb_dat_w[r] ),
            .o_wb_sel   ( o_wb_sel[r]   ),
            .i_wb_dat_r ( i_wb_dat_r[r] ),
            .i_wb_ack   ( i_wb_ack[r]   ),
            .o_done     ( port_done[r]  ),
            .o_rdata    ( port_rdata[r] ),
            .i_take     ( port_take[r]  )
        );
    end

    resp_merge u_resp_merge (
        .i_clk        ( i_clk        ),
        .i_reset      ( i_reset      ),
        .i_push       ( order_push   ),
        .i_tag        ( order_tag    ),
        .o_order_full ( order_full   ),
        .i_port_done  ( port_done    ),
        .i_port_rdata ( port_rdata   ),
        .o_port_take  ( port_take    ),
        .o_resp_valid ( o_resp_valid ),
        .o_resp_rdata ( o_resp_rdata ),
        .o_resp_err   ( o_resp_err   ),
        .i_resp_ready ( i_resp_ready )
    );

endmodule

// ==== hdl/region_pkg.sv ====
package region_pkg;

    localparam bus_pkg::region_t REGION_RAM  = bus_pkg::region_t'(0);
    localparam bus_pkg::region_t REGION_MMIO = bus_pkg::region_t'(1);

    // cached RAM, 64 KiB
    localparam bus_pkg::addr_t RAM_BASE  = bus_pkg::addr_t'(32'h0000_0000);
    localparam bus_pkg::addr_t RAM_MASK  = bus_pkg::addr_t'(32'hFFFF_0000);

    // uncached MMIO, 4 KiB
    localparam bus_pkg::addr_t MMIO_BASE = bus_pkg::addr_t'(32'h1FC0_0000);
    localparam bus_pkg::addr_t MMIO_MASK = bus_pkg::addr_t'(32'hFFFF_F000);

    function automatic bus_pkg::region_t region_of(input bus_pkg::addr_t addr);
        if ((addr & RAM_MASK) == RAM_BASE) begin
            return REGION_RAM;
        end
        if ((addr & MMIO_MASK) == MMIO_BASE) begin
            return REGION_MMIO;
        end
        return bus_pkg::REGION_NONE;
    endfunction

endpackage

// ==== hdl/req_router.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module req_router (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_req_valid,
    input  logic                        i_req_we,
    input  bus_pkg::addr_t              i_req_addr,
    input  bus_pkg::data_t              i_req_wdata,
    input  bus_pkg::strb_t              i_req_strb,
    input  logic [`MEM_NUM_REGIONS-1:0] i_port_full,
    input  logic                        i_order_full,
    output logic                        o_req_ready,
    output logic [`MEM_NUM_REGIONS-1:0] o_port_push,
    output bus_pkg::wb_req_t            o_port_entry,
    output logic                        o_order_push,
    output bus_pkg::region_t            o_order_tag
);
    import bus_pkg::*;
    import region_pkg::*;

    region_t region;
    logic    target_full;
    logic    accept;
    logic    armed;

    assign region = region_of(i_req_addr);

    // unmapped matches no port, so only the order queue counts
    always_comb begin
        target_full = 1'b0;
        for (int r = 0; r < `MEM_NUM_REGIONS; r++) begin
            if (region == region_t'(r)) begin
                target_full = i_port_full[r];
            end
        end
    end

    assign o_req_ready = armed && !i_order_full && !target_full;
    assign accept      = i_req_valid && o_req_ready;

    always_comb begin
        for (int r = 0; r < `MEM_NUM_REGIONS; r++) begin
            o_port_push[r] = accept && (region == region_t'(r));
        end
    end

    assign o_port_entry = '{we: i_req_we, adr: i_req_addr, dat: i_req_wdata, sel: i_req_strb};
    assign o_order_push = accept;   // same edge as the port push
    assign o_order_tag  = region;

    // keeps the CPU off while the queues come out of reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

endmodule

// ==== hdl/resp_merge.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module resp_merge (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_push,
    input  bus_pkg::region_t                      i_tag,
    output logic                                  o_order_full,
    input  logic [`MEM_NUM_REGIONS-1:0]           i_port_done,
    input  bus_pkg::data_t [`MEM_NUM_REGIONS-1:0] i_port_rdata,
    output logic [`MEM_NUM_REGIONS-1:0]           o_port_take,
    output logic                                  o_resp_valid,
    output bus_pkg::data_t                        o_resp_rdata,
    output logic                                  o_resp_err,
    input  logic                                  i_resp_ready
);
    import bus_pkg::*;

    region_t head_tag;
    logic    order_empty;
    logic    head_done;
    data_t   head_rdata;
    logic    unmapped;
    logic    fire;

    sync_fifo #(
        .T_ENTRY ( region_t         ),
        .DEPTH   ( `MEM_QUEUE_DEPTH )
    ) u_order_queue (
        .i_clk       ( i_clk        ),
        .i_reset     ( i_reset      ),
        .i_push      ( i_push       ),
        .i_push_data ( i_tag        ),
        .i_pop       ( fire         ),
        .o_pop_data  ( head_tag     ),
        .o_empty     ( order_empty  ),
        .o_full      ( o_order_full )
    );

    // REGION_NONE matches no port and leaves the data at zero
    always_comb begin
        head_done  = 1'b0;
        head_rdata = '0;
        for (int r = 0; r < `MEM_NUM_REGIONS; r++) begin
            if (head_tag == region_t'(r)) begin
                head_done  = i_port_done[r];
                head_rdata = i_port_rdata[r];
            end
        end
    end

    assign unmapped     = (head_tag == REGION_NONE);
    assign o_resp_valid = !order_empty && (unmapped || head_done);
    assign o_resp_err   = !order_empty && unmapped;
    assign o_resp_rdata = head_rdata;
    assign fire         = o_resp_valid && i_resp_ready;

    always_comb begin
        for (int r = 0; r < `MEM_NUM_REGIONS; r++) begin
            o_port_take[r] = fire && (head_tag == region_t'(r));
        end
    end

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T_ENTRY = logic,
    parameter int  DEPTH   = 4
) (
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_push,
    input  T_ENTRY i_push_data,
    input  logic   i_pop,
    output T_ENTRY o_pop_data,
    output logic   o_empty,
    output logic   o_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_ENTRY           mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty    = (count == '0);
    assign o_full     = (count == CNT_W'(DEPTH));
    assign do_pop     = i_pop && !o_empty;
    assign do_push    = i_push && (!o_full || do_pop);  // full is fine if the head leaves
    assign o_pop_data = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

endmodule

// ==== hdl/wb_master_port.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module wb_master_port (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_push,
    input  bus_pkg::wb_req_t i_entry,
    output logic             o_full,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic             o_wb_we,
    output bus_pkg::addr_t   o_wb_adr,
    output bus_pkg::data_t   o_wb_dat_w,
    output bus_pkg::strb_t   o_wb_sel,
    input  bus_pkg::data_t   i_wb_dat_r,
    input  logic             i_wb_ack,
    output logic             o_done,
    output bus_pkg::data_t   o_rdata,
    input  logic             i_take
);
    import bus_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t  state;
    wb_req_t head;
    logic    q_empty;
    logic    start;
    logic    bus_ack;

    sync_fifo #(
        .T_ENTRY ( wb_req_t         ),
        .DEPTH   ( `MEM_QUEUE_DEPTH )
    ) u_req_queue (
        .i_clk       ( i_clk   ),
        .i_reset     ( i_reset ),
        .i_push      ( i_push  ),
        .i_push_data ( i_entry ),
        .i_pop       ( bus_ack ),   // head stays put for the whole cycle
        .o_pop_data  ( head    ),
        .o_empty     ( q_empty ),
        .o_full      ( o_full  )
    );

    // one result slot, so wait for the merger to take it
    assign start   = (state == ST_IDLE) && !q_empty && !o_done;
    assign bus_ack = (state == ST_BUSY) && i_wb_ack;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= ST_IDLE;
            o_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state <= ST_BUSY;
                end
                ST_BUSY: if (i_wb_ack) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
            if (bus_ack) begin
                o_done <= 1'b1;
            end else if (i_take) begin
                o_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus_ack) begin
            o_rdata <= i_wb_dat_r;  // writes latch it too, merger returns it anyway
        end
    end

    assign o_wb_cyc   = (state == ST_BUSY);
    assign o_wb_stb   = (state == ST_BUSY);
    assign o_wb_we    = head.we;
    assign o_wb_adr   = head.adr;
    assign o_wb_dat_w = head.dat;
    assign o_wb_sel   = head.sel;

endmodule

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_subsys;
    import bus_pkg::*;
    import region_pkg::*;

    localparam int NR      = `MEM_NUM_REGIONS;
    localparam int N_INIT  = 4;
    localparam int N_WR    = 12;
    localparam int N_MIX   = 40;
    localparam int N_UNMAP = 6;
    localparam int N_STALL = 12;
    localparam int N_TOTAL = N_INIT + 2 * N_WR + N_MIX + N_UNMAP + N_STALL;

    logic             i_clk = 1'b0;
    logic             i_reset;
    logic             i_req_valid;
    logic             i_req_we;
    addr_t            i_req_addr;
    data_t            i_req_wdata;
    strb_t            i_req_strb;
    logic             o_req_ready;
    logic             o_resp_valid;
    data_t            o_resp_rdata;
    logic             o_resp_err;
    logic             i_resp_ready = 1'b0;
    logic [NR-1:0]    o_wb_cyc;
    logic [NR-1:0]    o_wb_stb;
    logic [NR-1:0]    o_wb_we;
    addr_t [NR-1:0]   o_wb_adr;
    data_t [NR-1:0]   o_wb_dat_w;
    strb_t [NR-1:0]   o_wb_sel;
    data_t [NR-1:0]   i_wb_dat_r = '0;
    logic [NR-1:0]    i_wb_ack = '0;

    int    seed = 369;
    logic  hold_resp = 1'b0;
    logic  slow_mmio = 1'b0;
    logic  saw_block = 1'b0;
    data_t slave_mem [addr_t];
    data_t ref_mem [addr_t];
    logic  in_cycle [NR];
    int    wait_left [NR];

    // expected responses in issue order
    data_t exp_data [$];
    logic  exp_err [$];
    logic  exp_chk [$];
    addr_t exp_addr [$];

    int    n_issued = 0;
    int    n_mapped = 0;
    int    n_resp = 0;
    int    n_acks = 0;
    int    n_checks = 0;
    int    n_mismatch = 0;
    int    n_other = 0;
    int    n_final = 0;
    logic  stalled;
    data_t held_rdata;
    logic [NR-1:0] pend;
    data_t e_data;
    logic  e_err;
    logic  e_chk;
    addr_t e_addr;
    addr_t wr_addr;

    mem_subsys_top mem_subsys_top_i (.*);

    always #5 i_clk = ~i_clk;

    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic data_t slave_word(input addr_t a);
        return slave_mem.exists(a) ? slave_mem[a] : (a ^ 32'hA5A5_A5A5);
    endfunction

    // reference model of the whole subsystem applied one access at a time
    function automatic void model_access(input logic we, input addr_t addr, input data_t wdata,
                                         input strb_t strb, output data_t data, output logic err);
        data_t old;
        err  = (region_of(addr) == REGION_NONE);
        data = '0;
        if (!err) begin
            old = ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ 32'hA5A5_A5A5);
            if (we) begin
                ref_mem[addr] = merge_bytes(old, wdata, strb);
            end else begin
                data = old;
            end
        end
    endfunction

    function automatic addr_t pick_addr(input int kind);
        addr_t off;
        off = addr_t'(($random(seed) & 32'h3F) << 2);  // 64 words so addresses repeat
        case (kind)
            0:       return 32'h0000_0000 | off;
            1:       return 32'h1FC0_0000 | off;
            default: return 32'h8000_0000 | off;
        endcase
    endfunction

    task automatic check_data(input data_t got, input data_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_region(input region_t got, input region_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0t ns: %s, region %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // called on a falling edge and returns on the falling edge after the handshake
    task automatic send(input logic we, input addr_t addr, input data_t wdata, input strb_t strb);
        data_t d;
        logic  e;
        i_req_valid = 1'b1;
        i_req_we    = we;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_strb  = strb;
        @(posedge i_clk);
        while (!o_req_ready) begin
            saw_block = 1'b1;
            @(posedge i_clk);
        end
        model_access(we, addr, wdata, strb, d, e);
        exp_data.push_back(d);
        exp_err.push_back(e);
        exp_chk.push_back(!we || e);  // write data comes back unchecked
        exp_addr.push_back(addr);
        n_issued++;
        if (!e) begin
            n_mapped++;
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    task automatic send_random(input int kinds);
        int kind;
        kind = ($random(seed) & 32'h7FFF_FFFF) % kinds;
        send(1'($random(seed)), pick_addr(kind), data_t'($random(seed)), strb_t'($random(seed)));
    endtask

    // wishbone slaves and the response ready
    always @(negedge i_clk) begin
        i_resp_ready = !i_reset && !hold_resp && (($random(seed) & 3) != 0);
        for (int r = 0; r < NR; r++) begin
            if (i_reset || i_wb_ack[r]) begin
                i_wb_ack[r] = 1'b0;     // ack lasts one clock
                in_cycle[r] = 1'b0;
            end else if (o_wb_cyc[r] && o_wb_stb[r]) begin
                if (!in_cycle[r]) begin
                    in_cycle[r]  = 1'b1;
                    wait_left[r] = (r == 1 && slow_mmio) ? 3 : ($random(seed) & 3);
                end
                if (wait_left[r] == 0) begin
                    i_wb_dat_r[r] = slave_word(o_wb_adr[r]);
                    if (o_wb_we[r]) begin
                        slave_mem[o_wb_adr[r]] = merge_bytes(i_wb_dat_r[r], o_wb_dat_w[r],
                                                             o_wb_sel[r]);
                    end
                    i_wb_ack[r] = 1'b1;
                    n_acks++;
                end else begin
                    wait_left[r]--;
                end
            end
        end
    end

    // response compare and bus monitor
    always @(posedge i_clk) begin
        if (i_reset) begin
            stalled = 1'b0;
            pend    = '0;
        end else begin
            if (stalled) begin
                if (!o_resp_valid) begin
                    n_other++;
                    $display("%0t ns: response withdrawn while the CPU was not ready", $time);
                end else begin
                    check_data(o_resp_rdata, held_rdata, "response data under back-pressure");
                end
            end
            if (o_resp_valid && i_resp_ready) begin
                if (exp_data.size() == 0) begin
                    n_other++;
                    $display("%0t ns: response arrived with no request outstanding", $time);
                end else begin
                    e_data = exp_data.pop_front();
                    e_err  = exp_err.pop_front();
                    e_chk  = exp_chk.pop_front();
                    e_addr = exp_addr.pop_front();
                    n_resp++;
                    check_err(o_resp_err, e_err, $sformatf("error flag for %h", e_addr));
                    if (e_chk) begin
                        check_data(o_resp_rdata, e_data, $sformatf("data for %h", e_addr));
                    end
                end
            end
            stalled    = o_resp_valid && !i_resp_ready;
            held_rdata = o_resp_rdata;
            for (int r = 0; r < NR; r++) begin
                if (pend[r] && !o_wb_cyc[r]) begin
                    n_other++;
                    $display("%0t ns: cyc on region %0d dropped before ack", $time, r);
                end
                if (o_wb_stb[r] !== o_wb_cyc[r]) begin
                    n_other++;
                    $display("%0t ns: stb and cyc differ on region %0d", $time, r);
                end
                if (o_wb_cyc[r]) begin
                    check_region(region_of(o_wb_adr[r]), region_t'(r),
                                 $sformatf("bus address %h on port %0d", o_wb_adr[r], r));
                end
                pend[r] = o_wb_cyc[r] && !i_wb_ack[r];
            end
        end
    end

    initial begin
        repeat (10 + 40 * N_TOTAL) @(posedge i_clk);
        $display("timeout: the run did not finish within %0d clocks", 10 + 40 * N_TOTAL);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        i_reset     = 1'b1;
        i_req_valid = 1'b0;
        i_req_we    = 1'b0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_strb  = '0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        // untouched RAM above the random window
        for (int i = 0; i < N_INIT; i++) begin
            send(1'b0, 32'h0000_0100 + i * 4, '0, '0);
        end

        for (int i = 0; i < N_WR; i++) begin
            wr_addr = pick_addr(i % 2);
            send(1'b1, wr_addr, data_t'($random(seed)), strb_t'($random(seed)));
            send(1'b0, wr_addr, '0, '0);
        end

        slow_mmio = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            send_random(2);
        end
        slow_mmio = 1'b0;

        // just past each window and then far away
        send(1'b0, 32'h0001_0000, '0, '0);
        send(1'b1, 32'h1FC0_1000, 32'hDEAD_BEEF, 4'hF);
        for (int i = 0; i < N_UNMAP - 2; i++) begin
            send(1'($random(seed)), pick_addr(2), data_t'($random(seed)), 4'hF);
        end

        @(posedge i_clk);
        hold_resp = 1'b1;
        saw_block = 1'b0;
        @(negedge i_clk);
        fork
            begin
                for (int i = 0; i < N_STALL; i++) begin
                    send_random(3);
                end
            end
            begin
                repeat (20 + ($random(seed) & 15)) @(posedge i_clk);
                if (!saw_block) begin
                    n_final++;
                    $display("o_req_ready never dropped while responses were held");
                end
                hold_resp = 1'b0;
            end
        join

        while (exp_data.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (10) @(posedge i_clk);  // catch late extra responses

        if (n_acks != n_mapped) begin
            n_final++;
            $display("%0d mapped requests but %0d bus cycles", n_mapped, n_acks);
        end

        $display("requests %0d, responses %0d, checks %0d, mismatches %0d, other failures %0d",
                 n_issued, n_resp, n_checks, n_mismatch, n_other + n_final);
        if (n_mismatch + n_other + n_final == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/region_pkg.sv
hdl/sync_fifo.sv
hdl/req_router.sv
hdl/wb_master_port.sv
hdl/resp_merge.sv
hdl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv
